//--- hw/mem_cdc_pkg.sv
package mem_cdc_pkg;

  // *******************************************************************
  // memory geometry
  // *******************************************************************

  localparam int addr_w    = 4;           // word address into the bank.
  localparam int data_w    = 32;          // one memory word.
  localparam int strb_w    = data_w / 8;  // one strobe per byte lane.
  localparam int mem_depth = 16;          // every address selects a word.

  // *******************************************************************
  // payloads carried by the crossings
  // *******************************************************************

  // A single access as issued by the requester.
  // A read ignores wdata and wstrb.
  typedef struct packed {
    logic              write;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
  } mem_req_t;

  // The bank always answers with the word as it stands after the access.
  typedef struct packed {
    logic [data_w-1:0] rdata;
  } mem_rsp_t;

endpackage

//--- hw/toggle_cdc.sv
`timescale 1ns/1ps

module toggle_cdc
  import mem_cdc_pkg::*;
#(
  parameter type payload_t = mem_req_t
) (
  input  logic     src_clk,
  input  logic     src_rstn,
  input  logic     src_valid,
  input  payload_t src_data,

  input  logic     dst_clk,
  input  logic     dst_rstn,
  output logic     dst_valid,
  output payload_t dst_data
);

  typedef enum logic {
    src_idle,
    src_wait
  } src_state_t;

  src_state_t state;
  src_state_t state_nxt;

  logic     src_take;     // strobe accepted by an idle source.
  logic     req_flag;     // toggles once per transfer, src domain.
  payload_t payload_reg;  // held stable while the flag crosses.

  logic     req_meta;
  logic     req_sync;
  logic     ack_flag;     // toggles once per delivery, dst domain.
  logic     ack_meta;
  logic     ack_sync;

  // *******************************************************************
  // source side
  // *******************************************************************

  assign src_take = (state == src_idle) && src_valid;

  always_comb begin
    state_nxt = state;
    case (state)
      src_idle: begin
        if (src_valid) begin
          state_nxt = src_wait;
        end
      end
      src_wait: begin
        // the flags match again once the acknowledge has come back.
        if (req_flag == ack_sync) begin
          state_nxt = src_idle;
        end
      end
      default: state_nxt = src_idle;
    endcase
  end

  always_ff @(posedge src_clk) begin
    if (!src_rstn) begin
      state    <= src_idle;
      req_flag <= 1'b0;
    end else begin
      state <= state_nxt;
      if (src_take) begin
        req_flag <= ~req_flag;
      end
    end
  end

  always_ff @(posedge src_clk) begin
    if (src_take) begin
      payload_reg <= src_data;
    end
  end

  always_ff @(posedge src_clk) begin
    if (!src_rstn) begin
      ack_meta <= 1'b0;
      ack_sync <= 1'b0;
    end else begin
      ack_meta <= ack_flag;
      ack_sync <= ack_meta;
    end
  end

  // *******************************************************************
  // destination side
  // *******************************************************************

  always_ff @(posedge dst_clk) begin
    if (!dst_rstn) begin
      req_meta <= 1'b0;
      req_sync <= 1'b0;
    end else begin
      req_meta <= req_flag;
      req_sync <= req_meta;
    end
  end

  // A flag mismatch means a new transfer has arrived.
  always_ff @(posedge dst_clk) begin
    if (!dst_rstn) begin
      ack_flag  <= 1'b0;
      dst_valid <= 1'b0;
      dst_data  <= '0;
    end else if (req_sync ^ ack_flag) begin
      ack_flag  <= ~ack_flag;
      dst_valid <= 1'b1;
      dst_data  <= payload_reg;  // stable since the flag left the source.
    end else begin
      dst_valid <= 1'b0;
      dst_data  <= '0;
    end
  end

endmodule

//--- hw/mem_bank.sv
`timescale 1ns/1ps

module mem_bank
  import mem_cdc_pkg::*;
(
  input  logic     dst_clk,
  input  logic     dst_rstn,

  input  logic     req_valid,
  input  mem_req_t req,

  output logic     rsp_valid,
  output mem_rsp_t rsp
);

  logic [data_w-1:0] mem [mem_depth];

  logic [data_w-1:0] cur_word;   // word at the requested address.
  logic [data_w-1:0] new_word;   // word after the access.

  // *******************************************************************
  // byte merge
  // *******************************************************************

  always_comb begin
    cur_word = mem[req.addr];
    new_word = cur_word;
    if (req.write) begin
      for (int i = 0; i < strb_w; i++) begin
        if (req.wstrb[i]) begin
          new_word[8*i +: 8] = req.wdata[8*i +: 8];
        end
      end
    end
  end

  // *******************************************************************
  // storage and response
  // *******************************************************************

  always_ff @(posedge dst_clk) begin
    if (!dst_rstn) begin
      for (int j = 0; j < mem_depth; j++) begin
        mem[j] <= '0;
      end
    end else if (req_valid && req.write) begin
      mem[req.addr] <= new_word;
    end
  end

  // One cycle from request to response, for reads and writes alike.
  always_ff @(posedge dst_clk) begin
    if (!dst_rstn) begin
      rsp_valid <= 1'b0;
      rsp       <= '0;
    end else begin
      rsp_valid <= req_valid;
      if (req_valid) begin
        rsp.rdata <= new_word;  // a read returns the word untouched.
      end
    end
  end

endmodule

//--- hw/src_port.sv
`timescale 1ns/1ps

module src_port
  import mem_cdc_pkg::*;
(
  input  logic              src_clk,
  input  logic              src_rstn,

  // requester side.
  input  logic              cpu_valid,
  input  logic              cpu_write,
  input  logic [addr_w-1:0] cpu_addr,
  input  logic [data_w-1:0] cpu_wdata,
  input  logic [strb_w-1:0] cpu_wstrb,
  output logic              cpu_busy,
  output logic              cpu_rsp_valid,
  output logic [data_w-1:0] cpu_rdata,

  // toward the request crossing.
  output logic              issue_valid,
  output mem_req_t          issue_req,

  // from the response crossing.
  input  logic              ret_valid,
  input  mem_rsp_t          ret_rsp
);

  // *******************************************************************
  // issue
  // *******************************************************************

  // While busy the request crossing may still be in flight, so
  // a strobe in that window is dropped here.
  assign issue_valid = cpu_valid && !cpu_busy;

  assign issue_req = '{
    write: cpu_write,
    addr:  cpu_addr,
    wdata: cpu_wdata,
    wstrb: cpu_wstrb
  };

  // *******************************************************************
  // outstanding access
  // *******************************************************************

  always_ff @(posedge src_clk) begin
    if (!src_rstn) begin
      cpu_busy <= 1'b0;
    end else if (ret_valid) begin
      cpu_busy <= 1'b0;   // falls together with cpu_rsp_valid rising.
    end else if (issue_valid) begin
      cpu_busy <= 1'b1;
    end
  end

  // *******************************************************************
  // response
  // *******************************************************************

  always_ff @(posedge src_clk) begin
    if (!src_rstn) begin
      cpu_rsp_valid <= 1'b0;
    end else begin
      cpu_rsp_valid <= ret_valid;
    end
  end

  // The data word is held until the next response replaces it.
  always_ff @(posedge src_clk) begin
    if (!src_rstn) begin
      cpu_rdata <= '0;
    end else if (ret_valid) begin
      cpu_rdata <= ret_rsp.rdata;
    end
  end

endmodule

//--- hw/mem_cdc_top.sv
`timescale 1ns/1ps

module mem_cdc_top
  import mem_cdc_pkg::*;
(
  input  logic              src_clk,
  input  logic              src_rstn,
  input  logic              dst_clk,
  input  logic              dst_rstn,

  input  logic              cpu_valid,
  input  logic              cpu_write,
  input  logic [addr_w-1:0] cpu_addr,
  input  logic [data_w-1:0] cpu_wdata,
  input  logic [strb_w-1:0] cpu_wstrb,
  output logic              cpu_busy,
  output logic              cpu_rsp_valid,
  output logic [data_w-1:0] cpu_rdata
);

  logic     issue_valid;
  mem_req_t issue_req;
  logic     bank_req_valid;
  mem_req_t bank_req;
  logic     bank_rsp_valid;
  mem_rsp_t bank_rsp;
  logic     ret_valid;
  mem_rsp_t ret_rsp;

  // *******************************************************************
  // src domain front end
  // *******************************************************************

  src_port u_src_port (
    .src_clk       (src_clk),
    .src_rstn      (src_rstn),
    .cpu_valid     (cpu_valid),
    .cpu_write     (cpu_write),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cpu_wstrb     (cpu_wstrb),
    .cpu_busy      (cpu_busy),
    .cpu_rsp_valid (cpu_rsp_valid),
    .cpu_rdata     (cpu_rdata),
    .issue_valid   (issue_valid),
    .issue_req     (issue_req),
    .ret_valid     (ret_valid),
    .ret_rsp       (ret_rsp)
  );

  // *******************************************************************
  // crossings and bank
  // *******************************************************************

  toggle_cdc #(.payload_t(mem_req_t)) u_req_cdc (
    .src_clk   (src_clk),
    .src_rstn  (src_rstn),
    .src_valid (issue_valid),
    .src_data  (issue_req),
    .dst_clk   (dst_clk),
    .dst_rstn  (dst_rstn),
    .dst_valid (bank_req_valid),
    .dst_data  (bank_req)
  );

  mem_bank u_mem_bank (
    .dst_clk   (dst_clk),
    .dst_rstn  (dst_rstn),
    .req_valid (bank_req_valid),
    .req       (bank_req),
    .rsp_valid (bank_rsp_valid),
    .rsp       (bank_rsp)
  );

  // the response runs the other way, so the clocks swap sides.
  toggle_cdc #(.payload_t(mem_rsp_t)) u_rsp_cdc (
    .src_clk   (dst_clk),
    .src_rstn  (dst_rstn),
    .src_valid (bank_rsp_valid),
    .src_data  (bank_rsp),
    .dst_clk   (src_clk),
    .dst_rstn  (src_rstn),
    .dst_valid (ret_valid),
    .dst_data  (ret_rsp)
  );

endmodule

//--- tests/mem_cdc_sva.sv
`timescale 1ns/1ps

module mem_cdc_sva
  import mem_cdc_pkg::*;
(
  input logic              src_clk,
  input logic              src_rstn,
  input logic              cpu_valid,
  input logic              cpu_busy,
  input logic              cpu_rsp_valid,
  input logic [data_w-1:0] cpu_rdata
);

  // *******************************************************************
  // reset
  // *******************************************************************

  // one edge with reset low leaves the port idle and cleared.
  a_reset_idle: assert property (
    @(posedge src_clk) !src_rstn |=> (!cpu_busy && !cpu_rsp_valid && cpu_rdata == '0)
  ) else $error("port is not idle and cleared after reset");

  // *******************************************************************
  // busy and response
  // *******************************************************************

  a_busy_on_accept: assert property (
    @(posedge src_clk) disable iff (!src_rstn)
    (cpu_valid && !cpu_busy) |=> cpu_busy
  ) else $error("cpu_busy did not rise after an accepted request");

  a_busy_falls_with_rsp: assert property (
    @(posedge src_clk) disable iff (!src_rstn)
    $fell(cpu_busy) |-> cpu_rsp_valid
  ) else $error("cpu_busy fell without a response");

  a_rsp_clears_busy: assert property (
    @(posedge src_clk) disable iff (!src_rstn)
    cpu_rsp_valid |-> $fell(cpu_busy)
  ) else $error("response arrived without cpu_busy falling on the same edge");

  a_rsp_one_cycle: assert property (
    @(posedge src_clk) disable iff (!src_rstn)
    cpu_rsp_valid |=> !cpu_rsp_valid
  ) else $error("cpu_rsp_valid stayed high for two cycles");

  // A response only ever answers an outstanding access.
  a_rsp_needs_busy: assert property (
    @(posedge src_clk) disable iff (!src_rstn)
    cpu_rsp_valid |-> $past(cpu_busy)
  ) else $error("response arrived while no access was outstanding");

endmodule

bind mem_cdc_top mem_cdc_sva u_mem_cdc_sva (
  .src_clk       (src_clk),
  .src_rstn      (src_rstn),
  .cpu_valid     (cpu_valid),
  .cpu_busy      (cpu_busy),
  .cpu_rsp_valid (cpu_rsp_valid),
  .cpu_rdata     (cpu_rdata)
);

//--- tests/mem_cdc_tb.sv
`timescale 1ns/1ps

module mem_cdc_tb
  import mem_cdc_pkg::*;
();

  localparam int rsp_timeout  = 200;  // src cycles allowed for one response.
  localparam int quiet_cycles = 40;   // far longer than one round trip.
  localparam int num_random   = 40;

  logic              src_clk;
  logic              src_rstn;
  logic              dst_clk;
  logic              dst_rstn;
  logic              cpu_valid;
  logic              cpu_write;
  logic [addr_w-1:0] cpu_addr;
  logic [data_w-1:0] cpu_wdata;
  logic [strb_w-1:0] cpu_wstrb;
  logic              cpu_busy;
  logic              cpu_rsp_valid;
  logic [data_w-1:0] cpu_rdata;

  integer            seed;
  logic [data_w-1:0] ref_mem [mem_depth];  // expected contents of the bank.

  mem_cdc_top u_mem_cdc_top (
    .src_clk       (src_clk),
    .src_rstn      (src_rstn),
    .dst_clk       (dst_clk),
    .dst_rstn      (dst_rstn),
    .cpu_valid     (cpu_valid),
    .cpu_write     (cpu_write),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cpu_wstrb     (cpu_wstrb),
    .cpu_busy      (cpu_busy),
    .cpu_rsp_valid (cpu_rsp_valid),
    .cpu_rdata     (cpu_rdata)
  );

  // *******************************************************************
  // clocks
  // *******************************************************************

  initial begin
    dst_clk = 1'b0;
    forever #20 dst_clk = ~dst_clk;
  end

  initial begin
    src_clk = 1'b0;
    forever #14 src_clk = ~src_clk;  // unrelated to dst_clk on purpose.
  end

  // *******************************************************************
  // checking helpers
  // *******************************************************************

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [data_w-1:0] expected,
                            input logic [data_w-1:0] actual);
    assert (actual === expected) else begin
      abort_run($sformatf("FAILED %s: expected %08h, actual %08h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      abort_run($sformatf("FAILED %s: expected %0b, actual %0b", name, expected, actual));
    end
  endtask

  // bytes with a strobe take the new data, the rest keep the old word.
  function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_word,
                                                    input logic [data_w-1:0] wdata,
                                                    input logic [strb_w-1:0] wstrb);
    logic [data_w-1:0] mask;
    for (int b = 0; b < strb_w; b++) begin
      mask[8*b +: 8] = {8{wstrb[b]}};
    end
    return (old_word & ~mask) | (wdata & mask);
  endfunction

  // *******************************************************************
  // stimulus
  // *******************************************************************

  // Called on a falling edge; returns on the next one with cpu_valid low.
  task automatic drive_request(input logic write, input logic [addr_w-1:0] addr,
                               input logic [data_w-1:0] wdata, input logic [strb_w-1:0] wstrb);
    cpu_valid = 1'b1;
    cpu_write = write;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    cpu_wstrb = wstrb;
    @(negedge src_clk);
    cpu_valid = 1'b0;
  endtask

  task automatic wait_response(input string name);
    int cycles;
    cycles = 0;
    while (cpu_rsp_valid !== 1'b1) begin
      if (cycles >= rsp_timeout) begin
        abort_run($sformatf("%s: no response within %0d src cycles", name, rsp_timeout));
      end
      @(negedge src_clk);
      cycles++;
    end
  endtask

  task automatic access(input string name, input logic write, input logic [addr_w-1:0] addr,
                        input logic [data_w-1:0] wdata, input logic [strb_w-1:0] wstrb);
    logic [data_w-1:0] expected;
    expected = ref_mem[addr];
    if (write) begin
      expected      = merge_bytes(ref_mem[addr], wdata, wstrb);
      ref_mem[addr] = expected;
    end
    drive_request(write, addr, wdata, wstrb);
    wait_response(name);
    check_word(name, expected, cpu_rdata);
    @(negedge src_clk);
  endtask

  task automatic random_access(input int idx);
    logic [data_w-1:0] rnd;
    logic [data_w-1:0] wdata;
    rnd   = $random(seed);
    wdata = $random(seed);
    // writes three times out of four, so strobes get exercised.
    access($sformatf("random access %0d", idx), rnd[1:0] != 2'b00, rnd[7:4], wdata, rnd[11:8]);
  endtask

  // Strobes while busy must vanish without a trace.
  task automatic busy_drop_test();
    logic [data_w-1:0] rnd;
    logic [addr_w-1:0] addr_a;
    logic [addr_w-1:0] addr_b;
    logic [data_w-1:0] expected;
    int                cycles;
    rnd      = $random(seed);
    addr_a   = rnd[addr_w-1:0];
    addr_b   = addr_a ^ 4'h8;
    expected = ref_mem[addr_a];
    drive_request(1'b0, addr_a, '0, '0);
    check_flag("busy after accept", 1'b1, cpu_busy);
    cpu_write = 1'b1;
    cpu_addr  = addr_b;
    cpu_wdata = ~ref_mem[addr_b];
    cpu_wstrb = {strb_w{1'b1}};
    cycles    = 0;
    // a write strobe every other cycle covers the whole busy window,
    // also the part after the request crossing has gone idle again.
    while (cpu_rsp_valid !== 1'b1) begin
      if (cycles >= rsp_timeout) begin
        abort_run($sformatf("read under busy: no response within %0d src cycles",
                            rsp_timeout));
      end
      cpu_valid = cpu_busy && !cpu_valid;
      @(negedge src_clk);
      cycles++;
    end
    cpu_valid = 1'b0;
    check_word("read under busy", expected, cpu_rdata);
    for (int c = 0; c < quiet_cycles; c++) begin
      @(negedge src_clk);
      check_flag("no extra response", 1'b0, cpu_rsp_valid);
    end
    access("dropped write leaves memory", 1'b0, addr_b, '0, '0);
  endtask

  // *******************************************************************
  // test sequence
  // *******************************************************************

  initial begin
    seed      = 32'h4e09;
    src_rstn  = 1'b0;
    dst_rstn  = 1'b0;
    cpu_valid = 1'b0;
    cpu_write = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    cpu_wstrb = '0;
    for (int i = 0; i < mem_depth; i++) begin
      ref_mem[i] = '0;
    end

    fork
      begin
        repeat (2) @(posedge src_clk);
        @(negedge src_clk);
        src_rstn = 1'b1;
      end
      begin
        repeat (2) @(posedge dst_clk);
        @(negedge dst_clk);
        dst_rstn = 1'b1;
      end
    join
    repeat (4) @(negedge src_clk);

    check_flag("reset busy", 1'b0, cpu_busy);
    check_word("reset rdata", '0, cpu_rdata);

    access("full word write", 1'b1, 4'h3, 32'hdead_beef, {strb_w{1'b1}});
    access("full word read", 1'b0, 4'h3, '0, '0);
    access("partial write", 1'b1, 4'h3, 32'h1234_5678, 4'b0101);  // lanes 0 and 2.
    access("partial read", 1'b0, 4'h3, '0, '0);

    for (int n = 0; n < num_random; n++) begin
      random_access(n);
    end

    busy_drop_test();

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- project.f
hw/mem_cdc_pkg.sv
hw/toggle_cdc.sv
hw/mem_bank.sv
hw/src_port.sv
hw/mem_cdc_top.sv
tests/mem_cdc_sva.sv
tests/mem_cdc_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory CDC testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_cdc_tb \
  -f project.f -o mem_cdc_sim > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/mem_cdc_sim > sim.log 2>&1
status=$?
cat sim.log

grep -q "Test failures found" sim.log && { echo "run failed"; exit 1; }
[ "$status" -eq 0 ] || { echo "simulation exited with status $status"; exit 1; }
echo "run passed"
exit 0
